//--- bench/state_recorder_chk.sv
`timescale 1ns/10ps
`default_nettype none

module state_recorder_chk #(
    parameter int unsigned dump_credits = 4,
    parameter int unsigned credit_width = 3
) (
    input logic                    m2,
    input logic                    reset,
    input logic                    rd_en,
    input logic                    dump_busy,
    input logic                    dump_valid,
    input logic                    credit_return,
    input logic [credit_width-1:0] credit_cnt
);

    // Bytes on the link not yet paid back, as the receiver sees them
    int link_used;

    always_ff @(posedge m2) begin
        if (reset) begin
            link_used <= 0;
        end else begin
            link_used <= link_used + int'(dump_valid) - int'(credit_return);
        end
    end

    // Credits can only come back after being spent
    credit_max: assert property (@(posedge m2) disable iff (reset)
        credit_cnt <= credit_width'(dump_credits))
        else $error("credit count above dump_credits");

    // The byte in flight also holds a receiver slot
    no_read_without_credit: assert property (@(posedge m2) disable iff (reset)
        rd_en |-> (link_used + int'(dump_valid) < int'(dump_credits)))
        else $error("read issued with no receiver space left");

    // Bytes only appear while a dump is running
    valid_inside_dump: assert property (@(posedge m2) disable iff (reset)
        dump_valid |-> dump_busy)
        else $error("dump_valid high outside a dump");

endmodule

bind snapshot_streamer state_recorder_chk #(
    .dump_credits (dump_credits),
    .credit_width (credit_width)
) state_recorder_chk_inst (
    .m2            (m2),
    .reset         (reset),
    .rd_en         (rd_en),
    .dump_busy     (dump_busy),
    .dump_valid    (dump_valid),
    .credit_return (credit_return),
    .credit_cnt    (credit_cnt)
);

`default_nettype wire

//--- bench/state_recorder_tb.sv
`timescale 1ns/10ps
`default_nettype none

module state_recorder_tb;

    localparam int unsigned dump_credits = 4;
    localparam int unsigned reset_cycles = 16;
    localparam int unsigned bus_cycle_budget = 4000;
    localparam int unsigned dump_count = 16;
    localparam int unsigned max_delay = 63;
    localparam int unsigned snap_len = nes_snoop_pkg::snapshot_len;
    localparam int unsigned timeout_cycles = reset_cycles + bus_cycle_budget +
        dump_count * snap_len * (dump_credits + max_delay) + 1000;

    logic        m2;
    logic        reset;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data;
    logic        cpu_rw;
    logic        dump_start;
    logic        credit_return;
    logic        dump_busy;
    logic        dump_valid;
    logic [7:0]  dump_data;

    // Reference model of the shadow state
    logic [7:0]  mirror [512];
    logic [7:0]  model_ptr;
    logic        model_toggle;

    logic [15:0] lfsr_state;
    int unsigned cycle_count;

    state_recorder #(
        .dump_credits (dump_credits)
    ) state_recorder_inst (
        .m2            (m2),
        .reset         (reset),
        .cpu_addr      (cpu_addr),
        .cpu_data      (cpu_data),
        .cpu_rw        (cpu_rw),
        .dump_start    (dump_start),
        .dump_busy     (dump_busy),
        .dump_valid    (dump_valid),
        .dump_data     (dump_data),
        .credit_return (credit_return)
    );

    always #20 m2 = !m2;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    always @(posedge m2) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            abort_run("Timeout, the run went past its cycle limit");
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int unsigned n);
        logic [15:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic apply_model(input logic [15:0] addr, input logic [7:0] data,
                               input logic rw);
        if (rw) begin
            if (addr == 16'h2002) begin
                model_toggle = 1'b0;
            end
        end else if (addr >= 16'h2000 && addr <= 16'h2007) begin
            case (addr[2:0])
                3'd0: mirror[9'h100] = data;
                3'd1: mirror[9'h103] = data;
                3'd3: model_ptr = data;
                3'd4: begin
                    mirror[{1'b0, model_ptr}] = data;
                    model_ptr = model_ptr + 8'd1;
                end
                3'd5: begin
                    mirror[model_toggle ? 9'h102 : 9'h101] = data;
                    model_toggle = !model_toggle;
                end
                3'd6: model_toggle = !model_toggle;
                default: ;
            endcase
        end else if (addr >= 16'h4000 && addr <= 16'h4017) begin
            mirror[9'h104 + 9'(addr[4:0])] = data;
        end
    endtask

    task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic rw);
        @(negedge m2);
        cpu_addr = addr;
        cpu_data = data;
        cpu_rw   = rw;
        apply_model(addr, data, rw);
    endtask

    // Runs one dump with the receiver returning credits after random delays
    task automatic run_dump(input int unsigned delay_bits, input logic poke);
        int unsigned rx_count;
        int unsigned level;
        int unsigned delay;
        rx_count = 0;
        level = 0;
        delay = 0;
        bus_cycle(16'h0000, 8'h00, 1'b1);
        dump_start = 1'b1;
        @(negedge m2);
        dump_start = 1'b0;
        assert (dump_busy) else abort_run("dump_busy did not rise after dump_start");
        while (dump_busy || level > 0) begin
            assert (!(dump_busy && !dump_valid && rx_count == snap_len))
                else abort_run("dump_busy stayed high after the last byte");
            if (dump_valid) begin
                assert (rx_count < snap_len) else abort_run("More bytes than one snapshot");
                assert (dump_data == mirror[rx_count])
                    else abort_run($sformatf("Fail dump_data at byte %h: got %h expected %h",
                                             rx_count, dump_data, mirror[rx_count]));
                rx_count++;
                level++;
                assert (level <= dump_credits) else abort_run("Receiver FIFO overflowed");
            end
            if (!dump_busy) begin
                assert (rx_count == snap_len) else abort_run("dump_busy fell before the last byte");
            end
            // Start request in the middle of a dump
            dump_start = poke && dump_busy && rx_count >= 100 && rx_count < 104;
            if (delay > 0) begin
                credit_return = 1'b0;
                delay--;
            end else if (level > 0) begin
                credit_return = 1'b1;
                level--;
                delay = rand_bits(delay_bits);
            end else begin
                credit_return = 1'b0;
            end
            @(negedge m2);
        end
        credit_return = 1'b0;
        dump_start = 1'b0;
        @(negedge m2);
        assert (!dump_busy && !dump_valid) else abort_run("Streamer restarted on its own");
    endtask

    initial begin
        logic [15:0] a;
        logic [7:0]  d;
        logic        rw;
        int unsigned n;
        m2 = 1'b0;
        reset = 1'b1;
        cpu_addr = 16'h0000;
        cpu_data = 8'h00;
        cpu_rw = 1'b1;
        dump_start = 1'b0;
        credit_return = 1'b0;
        lfsr_state = 16'd41440;
        cycle_count = 0;
        model_ptr = 8'h00;
        model_toggle = 1'b0;
        repeat (reset_cycles) @(negedge m2);
        reset = 1'b0;

        // Fill every slot first
        bus_cycle(16'h2002, 8'h00, 1'b1);
        bus_cycle(16'h2003, 8'h00, 1'b0);
        for (int i = 0; i < 256; i++)
            bus_cycle(16'h2004, 8'(rand_bits(8)), 1'b0);
        bus_cycle(16'h2000, 8'(rand_bits(8)), 1'b0);
        bus_cycle(16'h2001, 8'(rand_bits(8)), 1'b0);
        bus_cycle(16'h2005, 8'(rand_bits(8)), 1'b0);
        bus_cycle(16'h2005, 8'(rand_bits(8)), 1'b0);
        for (int i = 0; i < 24; i++)
            bus_cycle(16'h4000 + 16'(i), 8'(rand_bits(8)), 1'b0);
        run_dump(4, 1'b0);

        // Sprite pointer loads and runs, one forced wrap
        for (int run = 0; run < 8; run++) begin
            bus_cycle(16'h2003, 8'(rand_bits(8)), 1'b0);
            n = rand_bits(6) + 1;
            repeat (n) bus_cycle(16'h2004, 8'(rand_bits(8)), 1'b0);
        end
        bus_cycle(16'h2003, 8'hf8, 1'b0);
        repeat (20) bus_cycle(16'h2004, 8'(rand_bits(8)), 1'b0);
        run_dump(4, 1'b0);

        // Scroll writes against the shared toggle
        repeat (64) begin
            d = 8'(rand_bits(8));
            case (rand_bits(2))
                0, 1: bus_cycle(16'h2005, d, 1'b0);
                2: bus_cycle(16'h2006, d, 1'b0);
                default: bus_cycle(16'h2002, d, 1'b1);
            endcase
        end
        run_dump(4, 1'b0);

        // Cycles that must not touch the shadow
        repeat (64) begin
            d = 8'(rand_bits(8));
            case (rand_bits(3))
                0: bus_cycle(16'h2000, d, 1'b1);
                1: bus_cycle(16'h2004, d, 1'b1);
                2: bus_cycle(16'h2002, d, 1'b0);
                3: bus_cycle(16'h2006, d, 1'b0);
                4: bus_cycle(16'h2007, d, 1'b0);
                5: bus_cycle(16'h4018 + rand_bits(3), d, 1'b0);
                default: bus_cycle(16'h8000 | rand_bits(15), d, 1'b0);
            endcase
        end
        run_dump(4, 1'b0);

        // Slow receiver plus a start request while busy
        run_dump(6, 1'b1);

        // Random mix with periodic dumps
        for (int i = 1; i <= 2000; i++) begin
            case (rand_bits(2))
                0: a = 16'h2000 | rand_bits(3);
                1: a = 16'h4000 | rand_bits(5);
                2: a = rand_bits(16);
                default: a = 16'h2000 | rand_bits(3);
            endcase
            d = 8'(rand_bits(8));
            rw = (rand_bits(2) == 16'd0);
            bus_cycle(a, d, rw);
            if (i % 250 == 0) begin
                run_dump(4, 1'b0);
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/bus_decode.sv
`timescale 1ns/10ps
`default_nettype none

module bus_decode (
    input  logic                        m2,
    input  logic                        reset,

    // Snooped CPU bus
    input  logic [15:0]                 cpu_addr,
    input  logic [7:0]                  cpu_data,
    input  logic                        cpu_rw,

    // Shadow memory write port
    output logic                        wr_en,
    output nes_snoop_pkg::shadow_addr_t wr_addr,
    output logic [7:0]                  wr_data
);

    logic [7:0] oam_ptr;
    logic       write_toggle;

    logic       is_ppu_range;
    logic       is_apu_range;
    logic [2:0] ppu_reg;
    logic [4:0] apu_reg;

    assign ppu_reg = cpu_addr[2:0];
    assign apu_reg = cpu_addr[4:0];

    // $2000-$2007, mirrors above $2007 are not decoded
    assign is_ppu_range = (cpu_addr[15:3] == nes_snoop_pkg::ppu_range_base[15:3]);

    // $4000-$4017 only, $4018 and up are test registers
    assign is_apu_range = (cpu_addr[15:5] == nes_snoop_pkg::apu_range_base[15:5]) &&
                          (apu_reg < 5'(nes_snoop_pkg::apu_reg_count));

    // Data always comes straight off the bus
    assign wr_data = cpu_data;

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = nes_snoop_pkg::oam_base;

        if (!reset && !cpu_rw) begin
            if (is_ppu_range) begin
                case (ppu_reg)
                    nes_snoop_pkg::reg_ppu_ctrl: begin
                        wr_en   = 1'b1;
                        wr_addr = nes_snoop_pkg::ppu_ctrl_slot;
                    end
                    nes_snoop_pkg::reg_ppu_mask: begin
                        wr_en   = 1'b1;
                        wr_addr = nes_snoop_pkg::ppu_mask_slot;
                    end
                    nes_snoop_pkg::reg_oam_data: begin
                        wr_en   = 1'b1;
                        wr_addr = nes_snoop_pkg::oam_base +
                                  nes_snoop_pkg::shadow_addr_t'(oam_ptr);
                    end
                    nes_snoop_pkg::reg_ppu_scroll: begin
                        // Toggle picks X or Y half
                        wr_en   = 1'b1;
                        wr_addr = write_toggle ? nes_snoop_pkg::ppu_scroll_second_slot
                                               : nes_snoop_pkg::ppu_scroll_first_slot;
                    end
                    default: begin
                        wr_en = 1'b0;
                    end
                endcase
            end else if (is_apu_range) begin
                wr_en   = 1'b1;
                wr_addr = nes_snoop_pkg::apu_base_slot +
                          nes_snoop_pkg::shadow_addr_t'(apu_reg);
            end
        end
    end

    // Sprite pointer and the shared $2005/$2006 latch
    always_ff @(posedge m2) begin
        if (reset) begin
            oam_ptr      <= '0;
            write_toggle <= 1'b0;
        end else if (is_ppu_range) begin
            if (cpu_rw) begin
                // Status read clears the latch
                if (ppu_reg == nes_snoop_pkg::reg_ppu_status) begin
                    write_toggle <= 1'b0;
                end
            end else begin
                case (ppu_reg)
                    nes_snoop_pkg::reg_oam_addr: begin
                        oam_ptr <= cpu_data;
                    end
                    nes_snoop_pkg::reg_oam_data: begin
                        // Wraps past 255
                        oam_ptr <= oam_ptr + 8'd1;
                    end
                    nes_snoop_pkg::reg_ppu_scroll,
                    nes_snoop_pkg::reg_ppu_addr: begin
                        write_toggle <= !write_toggle;
                    end
                    default: begin
                        oam_ptr <= oam_ptr;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/nes_snoop_pkg.sv
`default_nettype none

package nes_snoop_pkg;

    // Shadow memory geometry
    localparam int unsigned shadow_addr_width = 9;
    localparam int unsigned shadow_depth = 1 << shadow_addr_width;

    typedef logic [shadow_addr_width-1:0] shadow_addr_t;

    // Sprite attribute memory occupies the low 256 bytes
    localparam shadow_addr_t oam_base = 9'h000;

    // Picture unit register slots
    localparam shadow_addr_t ppu_ctrl_slot = 9'h100;
    localparam shadow_addr_t ppu_scroll_first_slot = 9'h101;
    localparam shadow_addr_t ppu_scroll_second_slot = 9'h102;
    localparam shadow_addr_t ppu_mask_slot = 9'h103;

    // Audio and I/O registers $4000 upward
    localparam shadow_addr_t apu_base_slot = 9'h104;

    // Sprite memory through the last audio slot
    localparam int unsigned snapshot_len = 284;

    // CPU bus windows
    localparam logic [15:0] ppu_range_base = 16'h2000;
    localparam logic [15:0] apu_range_base = 16'h4000;
    localparam int unsigned apu_reg_count = 24;

    // Register offsets in the $2000-$2007 window
    localparam logic [2:0] reg_ppu_ctrl = 3'd0;
    localparam logic [2:0] reg_ppu_mask = 3'd1;
    localparam logic [2:0] reg_ppu_status = 3'd2;
    localparam logic [2:0] reg_oam_addr = 3'd3;
    localparam logic [2:0] reg_oam_data = 3'd4;
    localparam logic [2:0] reg_ppu_scroll = 3'd5;
    localparam logic [2:0] reg_ppu_addr = 3'd6;

endpackage

`default_nettype wire

//--- hw/shadow_ram.sv
`timescale 1ns/10ps
`default_nettype none

module shadow_ram (
    input  logic                        m2,

    // Write side, fed by the bus decoder
    input  logic                        wr_en,
    input  nes_snoop_pkg::shadow_addr_t wr_addr,
    input  logic [7:0]                  wr_data,

    // Read side, owned by the snapshot streamer
    input  logic                        rd_en,
    input  nes_snoop_pkg::shadow_addr_t rd_addr,
    output logic [7:0]                  rd_data
);

    // Plain array so synthesis maps it to block RAM
    logic [7:0] mem [nes_snoop_pkg::shadow_depth];

    always_ff @(posedge m2) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, holds its value while rd_en is low
    always_ff @(posedge m2) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hw/snapshot_streamer.sv
`timescale 1ns/10ps
`default_nettype none

module snapshot_streamer #(
    parameter int unsigned dump_credits = 4
) (
    input  logic                        m2,
    input  logic                        reset,

    // Control
    input  logic                        dump_start,
    output logic                        dump_busy,

    // Shadow memory read port
    output logic                        rd_en,
    output nes_snoop_pkg::shadow_addr_t rd_addr,
    input  logic [7:0]                  rd_data,

    // Credit based byte link
    output logic                        dump_valid,
    output logic [7:0]                  dump_data,
    input  logic                        credit_return
);

    localparam int unsigned credit_width = $clog2(dump_credits + 1);

    localparam nes_snoop_pkg::shadow_addr_t last_addr =
        nes_snoop_pkg::shadow_addr_t'(nes_snoop_pkg::snapshot_len);

    nes_snoop_pkg::shadow_addr_t addr_cnt;
    logic [credit_width-1:0]     credit_cnt;
    logic                        reads_left;
    logic                        dump_done;

    assign reads_left = (addr_cnt < last_addr);

    // Issue a read only when the receiver has room for its byte
    assign rd_en   = dump_busy && reads_left && (credit_cnt != '0);
    assign rd_addr = addr_cnt;

    // Last read already issued and its byte is on the link now
    assign dump_done = dump_valid && !reads_left;

    // RAM output is one cycle behind the read, same as the valid flag
    assign dump_data = rd_data;

    always_ff @(posedge m2) begin
        if (reset) begin
            dump_busy <= 1'b0;
        end else if (!dump_busy) begin
            // Start requests while busy are dropped
            dump_busy <= dump_start;
        end else if (dump_done) begin
            dump_busy <= 1'b0;
        end
    end

    always_ff @(posedge m2) begin
        if (reset) begin
            addr_cnt <= '0;
        end else if (!dump_busy && dump_start) begin
            addr_cnt <= '0;
        end else if (rd_en) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // Spend on issue, refund on return, both at once cancel out
    always_ff @(posedge m2) begin
        if (reset) begin
            credit_cnt <= credit_width'(dump_credits);
        end else begin
            case ({rd_en, credit_return})
                2'b10: begin
                    credit_cnt <= credit_cnt - 1'b1;
                end
                2'b01: begin
                    credit_cnt <= credit_cnt + 1'b1;
                end
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

    // One stage valid pipe matching the RAM read latency
    always_ff @(posedge m2) begin
        if (reset) begin
            dump_valid <= 1'b0;
        end else begin
            dump_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

//--- hw/state_recorder.sv
`timescale 1ns/10ps
`default_nettype none

module state_recorder #(
    parameter int unsigned dump_credits = 4
) (
    input  logic        m2,
    input  logic        reset,

    // Snooped CPU bus
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_data,
    input  logic        cpu_rw,

    // Snapshot control and byte link
    input  logic        dump_start,
    output logic        dump_busy,
    output logic        dump_valid,
    output logic [7:0]  dump_data,
    input  logic        credit_return
);

    logic                        wr_en;
    nes_snoop_pkg::shadow_addr_t wr_addr;
    logic [7:0]                  wr_data;

    logic                        rd_en;
    nes_snoop_pkg::shadow_addr_t rd_addr;
    logic [7:0]                  rd_data;

    // Decode stage
    bus_decode bus_decode_inst (
        .m2       (m2),
        .reset    (reset),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_rw   (cpu_rw),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // Shadow copy of the write-only state
    shadow_ram shadow_ram_inst (
        .m2      (m2),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Dump out over the credit link
    snapshot_streamer #(
        .dump_credits (dump_credits)
    ) snapshot_streamer_inst (
        .m2            (m2),
        .reset         (reset),
        .dump_start    (dump_start),
        .dump_busy     (dump_busy),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .dump_valid    (dump_valid),
        .dump_data     (dump_data),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

//--- list.f
hw/nes_snoop_pkg.sv
hw/bus_decode.sv
hw/shadow_ram.sv
hw/snapshot_streamer.sv
hw/state_recorder.sv
bench/state_recorder_chk.sv
bench/state_recorder_tb.sv
